// ==== filelist.f ====
+incdir+hdl
hdl/riscv_pkg.sv
hdl/exec_if.sv
hdl/decoder.sv
hdl/alu.sv
hdl/gpr_file.sv
hdl/load_store_unit.sv
hdl/pc_counter.sv
hdl/core_fsm.sv
hdl/riscv_core.sv
verif/riscv_core_tb.sv
verif/riscv_core_assert.sv

// ==== hdl/alu.sv ====
module alu (
    exec_if.exe              ex,
    output riscv_pkg::word_t result
);

    logic [4:0] shamt;

    assign shamt = ex.alu_in_1[4:0]; // rs2[4:0] or imm[4:0]

    always_comb begin
        case (ex.alu_op)
            riscv_pkg::ALU_ADD:    result = ex.alu_in_0 + ex.alu_in_1;
            riscv_pkg::ALU_SUB:    result = ex.alu_in_0 - ex.alu_in_1;
            riscv_pkg::ALU_SLT: begin
                result = {31'b0, $signed(ex.alu_in_0) < $signed(ex.alu_in_1)};
            end
            riscv_pkg::ALU_SLTU:   result = {31'b0, ex.alu_in_0 < ex.alu_in_1};
            riscv_pkg::ALU_AND:    result = ex.alu_in_0 & ex.alu_in_1;
            riscv_pkg::ALU_OR:     result = ex.alu_in_0 | ex.alu_in_1;
            riscv_pkg::ALU_XOR:    result = ex.alu_in_0 ^ ex.alu_in_1;
            riscv_pkg::ALU_SLL:    result = ex.alu_in_0 << shamt;
            riscv_pkg::ALU_SRL:    result = ex.alu_in_0 >> shamt;
            riscv_pkg::ALU_SRA:    result = $signed(ex.alu_in_0) >>> shamt; // keeps sign
            riscv_pkg::ALU_PASS_B: result = ex.alu_in_1;
            default:               result = '0; // nop
        endcase
    end

endmodule

// ==== hdl/core_fsm.sv ====
module core_fsm (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_pkg::word_t     insn_in,
    output riscv_pkg::word_t     insn,
    input  riscv_pkg::exp_code_e exp_in,
    output logic                 retire,
    output logic                 halted,
    output riscv_pkg::exp_code_e exp_code
);

    riscv_pkg::core_state_e state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= riscv_pkg::FETCH;
            exp_code <= riscv_pkg::NO_EXP;
        end else begin
            case (state)
                riscv_pkg::FETCH: state <= riscv_pkg::EXEC;
                riscv_pkg::EXEC: begin
                    if (exp_in != riscv_pkg::NO_EXP) begin
                        state    <= riscv_pkg::HALT; // sticky until reset
                        exp_code <= exp_in;
                    end else begin
                        state <= riscv_pkg::FETCH;
                    end
                end
                default: state <= riscv_pkg::HALT;
            endcase
        end
    end

    // instruction register, loaded at the FETCH edge
    always_ff @(posedge clk) begin
        if (state == riscv_pkg::FETCH) insn <= insn_in;
    end

    assign retire = (state == riscv_pkg::EXEC) && (exp_in == riscv_pkg::NO_EXP);
    assign halted = (state == riscv_pkg::HALT);

endmodule

// ==== hdl/decoder.sv ====
module decoder (
    input  riscv_pkg::word_t      insn,
    input  riscv_pkg::word_t      pc,
    output riscv_pkg::gpr_addr_t  rs1_addr,
    output riscv_pkg::gpr_addr_t  rs2_addr,
    input  riscv_pkg::word_t      rs1_data,
    input  riscv_pkg::word_t      rs2_data,
    exec_if.dec                   ex,
    output riscv_pkg::word_t      br_addr,
    output logic                  br_taken,
    output riscv_pkg::exp_code_e  exp_code
);

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_s;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm_u;
    riscv_pkg::word_t imm_j;
    riscv_pkg::word_t jalr_sum;

    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    // register read addresses come straight from the fields
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    assign jalr_sum = rs1_data + imm_i;

    always_comb begin
        ex.alu_op     = riscv_pkg::ALU_NOP; // inactive defaults
        ex.alu_in_0   = rs1_data;
        ex.alu_in_1   = rs2_data;
        ex.mem_op     = riscv_pkg::MEM_NOP;
        ex.store_data = rs2_data;
        ex.dst_addr   = insn[11:7];
        ex.gpr_we_n   = 1'b1;
        br_addr       = pc + imm_b;
        br_taken      = 1'b0;
        exp_code      = riscv_pkg::NO_EXP;
        case (insn[6:0])
            riscv_pkg::OPC_OP_IMM: begin
                ex.alu_in_1 = imm_i;
                ex.gpr_we_n = 1'b0;
                case (funct3)
                    3'b000: ex.alu_op = riscv_pkg::ALU_ADD;
                    3'b010: ex.alu_op = riscv_pkg::ALU_SLT;
                    3'b011: ex.alu_op = riscv_pkg::ALU_SLTU; // unsigned vs sign-extended imm
                    3'b100: ex.alu_op = riscv_pkg::ALU_XOR;
                    3'b110: ex.alu_op = riscv_pkg::ALU_OR;
                    3'b111: ex.alu_op = riscv_pkg::ALU_AND;
                    3'b001: begin
                        if (funct7 == 7'b0000000) ex.alu_op = riscv_pkg::ALU_SLL;
                        else exp_code = riscv_pkg::UNDEF_INSN;
                    end
                    default: begin // 3'b101
                        if (funct7 == 7'b0000000) ex.alu_op = riscv_pkg::ALU_SRL;
                        else if (funct7 == 7'b0100000) ex.alu_op = riscv_pkg::ALU_SRA;
                        else exp_code = riscv_pkg::UNDEF_INSN;
                    end
                endcase
            end
            riscv_pkg::OPC_OP: begin
                ex.gpr_we_n = 1'b0;
                case ({funct7, funct3})
                    10'b0000000_000: ex.alu_op = riscv_pkg::ALU_ADD;
                    10'b0100000_000: ex.alu_op = riscv_pkg::ALU_SUB;
                    10'b0000000_001: ex.alu_op = riscv_pkg::ALU_SLL;
                    10'b0000000_010: ex.alu_op = riscv_pkg::ALU_SLT;
                    10'b0000000_011: ex.alu_op = riscv_pkg::ALU_SLTU;
                    10'b0000000_100: ex.alu_op = riscv_pkg::ALU_XOR;
                    10'b0000000_101: ex.alu_op = riscv_pkg::ALU_SRL;
                    10'b0100000_101: ex.alu_op = riscv_pkg::ALU_SRA;
                    10'b0000000_110: ex.alu_op = riscv_pkg::ALU_OR;
                    10'b0000000_111: ex.alu_op = riscv_pkg::ALU_AND;
                    default: exp_code = riscv_pkg::UNDEF_INSN;
                endcase
            end
            riscv_pkg::OPC_LUI: begin
                ex.alu_op   = riscv_pkg::ALU_PASS_B; // rd = imm << 12
                ex.alu_in_1 = imm_u;
                ex.gpr_we_n = 1'b0;
            end
            riscv_pkg::OPC_AUIPC: begin
                ex.alu_op   = riscv_pkg::ALU_ADD;
                ex.alu_in_0 = pc;
                ex.alu_in_1 = imm_u;
                ex.gpr_we_n = 1'b0;
            end
            riscv_pkg::OPC_JAL: begin
                ex.alu_op   = riscv_pkg::ALU_ADD; // link = pc + 4
                ex.alu_in_0 = pc;
                ex.alu_in_1 = 32'd4;
                ex.gpr_we_n = 1'b0;
                br_addr     = pc + imm_j;
                br_taken    = 1'b1;
            end
            riscv_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ex.alu_op   = riscv_pkg::ALU_ADD;
                    ex.alu_in_0 = pc;
                    ex.alu_in_1 = 32'd4;
                    ex.gpr_we_n = 1'b0;
                    br_addr     = {jalr_sum[31:1], 1'b0}; // bit 0 cleared
                    br_taken    = 1'b1;
                end else begin
                    exp_code = riscv_pkg::UNDEF_INSN;
                end
            end
            riscv_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: br_taken = (rs1_data == rs2_data);
                    3'b001: br_taken = (rs1_data != rs2_data);
                    3'b100: br_taken = ($signed(rs1_data) < $signed(rs2_data));
                    3'b101: br_taken = ($signed(rs1_data) >= $signed(rs2_data));
                    3'b110: br_taken = (rs1_data < rs2_data);
                    3'b111: br_taken = (rs1_data >= rs2_data);
                    default: exp_code = riscv_pkg::UNDEF_INSN;
                endcase
            end
            riscv_pkg::OPC_LOAD: begin
                ex.alu_op   = riscv_pkg::ALU_ADD; // effective address
                ex.alu_in_1 = imm_i;
                ex.gpr_we_n = 1'b0;
                case (funct3)
                    3'b000: ex.mem_op = riscv_pkg::MEM_LB;
                    3'b001: ex.mem_op = riscv_pkg::MEM_LH;
                    3'b010: ex.mem_op = riscv_pkg::MEM_LW;
                    3'b100: ex.mem_op = riscv_pkg::MEM_LBU;
                    3'b101: ex.mem_op = riscv_pkg::MEM_LHU;
                    default: begin
                        ex.gpr_we_n = 1'b1;
                        exp_code    = riscv_pkg::UNDEF_INSN;
                    end
                endcase
            end
            riscv_pkg::OPC_STORE: begin
                ex.alu_op   = riscv_pkg::ALU_ADD;
                ex.alu_in_1 = imm_s;
                case (funct3)
                    3'b000: ex.mem_op = riscv_pkg::MEM_SB;
                    3'b001: ex.mem_op = riscv_pkg::MEM_SH;
                    3'b010: ex.mem_op = riscv_pkg::MEM_SW;
                    default: exp_code = riscv_pkg::UNDEF_INSN;
                endcase
            end
            default: exp_code = riscv_pkg::UNDEF_INSN; // also MISC-MEM and SYSTEM
        endcase
    end

endmodule

// ==== hdl/exec_if.sv ====
interface exec_if;

    riscv_pkg::alu_op_e   alu_op;
    riscv_pkg::word_t     alu_in_0;   // rs1 or pc
    riscv_pkg::word_t     alu_in_1;   // rs2, immediate or 4
    riscv_pkg::mem_op_e   mem_op;
    riscv_pkg::word_t     store_data; // raw rs2, lanes placed by the lsu
    riscv_pkg::gpr_addr_t dst_addr;
    logic                 gpr_we_n;   // low = write rd

    modport dec (output alu_op, alu_in_0, alu_in_1, mem_op, store_data, dst_addr, gpr_we_n);

    modport exe (input alu_op, alu_in_0, alu_in_1);

    modport lsu (input mem_op, store_data, dst_addr, gpr_we_n);

endinterface

// ==== hdl/gpr_file.sv ====
`include "riscv_defs.svh"

module gpr_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_pkg::gpr_addr_t rs1_addr,
    input  riscv_pkg::gpr_addr_t rs2_addr,
    output riscv_pkg::word_t     rs1_data,
    output riscv_pkg::word_t     rs2_data,
    input  logic                 we,
    input  riscv_pkg::gpr_addr_t rd_addr,
    input  riscv_pkg::word_t     rd_data,
    input  riscv_pkg::gpr_addr_t dbg_addr,
    output riscv_pkg::word_t     dbg_data
);

    riscv_pkg::word_t regs [`GPR_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `GPR_NUM; i++) regs[i] <= '0;
        end else if (we && rd_addr != '0) begin // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr]; // async reads
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

// ==== hdl/load_store_unit.sv ====
`include "riscv_defs.svh"

module load_store_unit (
    input  logic             clk,
    exec_if.lsu              ex,
    input  riscv_pkg::word_t alu_result,
    input  logic             commit,
    output riscv_pkg::word_t wb_data,
    output logic             gpr_we
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    riscv_pkg::word_t dmem [`DMEM_WORDS];

    logic [IDX_W-1:0] idx;
    logic [1:0]       ofs;
    logic [3:0]       be;
    riscv_pkg::word_t wdata;
    riscv_pkg::word_t rword;
    riscv_pkg::word_t load_val;
    logic             is_load;

    assign idx   = alu_result[IDX_W+1:2]; // word index, wraps inside the memory
    assign ofs   = alu_result[1:0];
    assign rword = dmem[idx] >> {ofs, 3'b000}; // selected lane moved to bit 0

    always_comb begin
        be    = 4'b0000;
        wdata = ex.store_data;
        case (ex.mem_op)
            riscv_pkg::MEM_SB: begin
                be    = 4'b0001 << ofs;
                wdata = {4{ex.store_data[7:0]}};
            end
            riscv_pkg::MEM_SH: begin
                be    = 4'b0011 << {ofs[1], 1'b0};
                wdata = {2{ex.store_data[15:0]}};
            end
            riscv_pkg::MEM_SW: be = 4'b1111;
            default: be = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) dmem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_comb begin
        is_load  = 1'b1;
        case (ex.mem_op)
            riscv_pkg::MEM_LB:  load_val = {{24{rword[7]}}, rword[7:0]};
            riscv_pkg::MEM_LH:  load_val = {{16{rword[15]}}, rword[15:0]};
            riscv_pkg::MEM_LW:  load_val = rword;
            riscv_pkg::MEM_LBU: load_val = {24'b0, rword[7:0]};
            riscv_pkg::MEM_LHU: load_val = {16'b0, rword[15:0]};
            default: begin
                is_load  = 1'b0;
                load_val = '0;
            end
        endcase
    end

    assign wb_data = is_load ? load_val : alu_result;
    assign gpr_we  = commit && !ex.gpr_we_n && ex.dst_addr != '0; // drop x0 writes early

endmodule

// ==== hdl/pc_counter.sv ====
`include "riscv_defs.svh"

module pc_counter (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             advance,
    input  logic             br_taken,
    input  riscv_pkg::word_t br_addr,
    output riscv_pkg::word_t pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (advance) begin
            pc <= br_taken ? br_addr : pc + 32'd4; // jump or fall through
        end
    end

endmodule

// ==== hdl/riscv_core.sv ====
module riscv_core (
    input  logic                 clk,
    input  logic                 arst_n,
    output riscv_pkg::word_t     insn_addr,
    input  riscv_pkg::word_t     insn,
    output logic                 retire,
    output logic                 halted,
    output riscv_pkg::exp_code_e exp_code,
    input  riscv_pkg::gpr_addr_t dbg_addr,
    output riscv_pkg::word_t     dbg_data
);

    riscv_pkg::word_t     pc;
    riscv_pkg::word_t     insn_q;
    riscv_pkg::gpr_addr_t rs1_addr;
    riscv_pkg::gpr_addr_t rs2_addr;
    riscv_pkg::word_t     rs1_data;
    riscv_pkg::word_t     rs2_data;
    riscv_pkg::word_t     br_addr;
    logic                 br_taken;
    riscv_pkg::exp_code_e dec_exp;
    riscv_pkg::word_t     alu_result;
    riscv_pkg::word_t     wb_data;
    logic                 gpr_we;

    exec_if ex ();

    assign insn_addr = pc; // fetch address held through FETCH and EXEC

    core_fsm core_fsm_inst (
        .clk, .arst_n, .insn_in(insn), .insn(insn_q), .exp_in(dec_exp),
        .retire, .halted, .exp_code
    );

    decoder decoder_inst (
        .insn(insn_q), .pc, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex(ex.dec), .br_addr, .br_taken, .exp_code(dec_exp)
    );

    alu alu_inst (.ex(ex.exe), .result(alu_result));

    gpr_file gpr_file_inst (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we(gpr_we), .rd_addr(ex.dst_addr), .rd_data(wb_data), .dbg_addr, .dbg_data
    );

    load_store_unit load_store_unit_inst (
        .clk, .ex(ex.lsu), .alu_result, .commit(retire), .wb_data, .gpr_we
    );

    pc_counter pc_counter_inst (
        .clk, .arst_n, .advance(retire), .br_taken, .br_addr, .pc
    );

endmodule

// ==== hdl/riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// data and address width
`define XLEN 32

// architectural register count, x0 included
`define GPR_NUM 32

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// address of the first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/riscv_pkg.sv ====
`include "riscv_defs.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`GPR_NUM)-1:0] gpr_addr_t;

    // major opcodes, insn[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    // nine encodings, so one bit more than a 3-bit field holds
    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        NO_EXP,
        UNDEF_INSN
    } exp_code_e;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        HALT
    } core_state_e;

endpackage

// ==== verif/riscv_core_assert.sv ====
module riscv_core_assert (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   retire,
    input logic                   halted,
    input riscv_pkg::word_t       insn_addr,
    input riscv_pkg::core_state_e state
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // a retiring insn follows a FETCH and is followed by the next FETCH
    retire_in_exec: assert property (@(posedge clk) disable iff (!arst_n)
        retire |-> ($past(state) == riscv_pkg::FETCH) ##1 (state == riscv_pkg::FETCH))
        else begin
            $error("retire outside the EXEC cycle or followed by a halt");
            fail_cnt++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else begin
            $error("halted dropped without reset");
            fail_cnt++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        insn_addr[1:0] == 2'b00)
        else begin
            $error("insn_addr not word aligned");
            fail_cnt++;
        end

    // every insn takes two cycles
    single_retire: assert property (@(posedge clk) disable iff (!arst_n)
        retire |=> !retire)
        else begin
            $error("retire high on two consecutive cycles");
            fail_cnt++;
        end

endmodule

bind riscv_core riscv_core_assert riscv_core_assert_inst (
    .clk(clk),
    .arst_n(arst_n),
    .retire(retire),
    .halted(halted),
    .insn_addr(insn_addr),
    .state(core_fsm_inst.state)
);

// ==== verif/riscv_core_tb.sv ====
`include "riscv_defs.svh"

module riscv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // about 90 retired insns x2, seven resets, ~50 debug reads, then margin
    localparam int TIMEOUT_CYCLES = 600;

    logic                 clk;
    logic                 arst_n;
    riscv_pkg::word_t     insn_addr;
    riscv_pkg::word_t     insn;
    logic                 retire;
    logic                 halted;
    riscv_pkg::exp_code_e exp_code;
    riscv_pkg::gpr_addr_t dbg_addr;
    riscv_pkg::word_t     dbg_data;

    riscv_pkg::word_t rom [64];       // instruction memory model
    int               rom_len;
    riscv_pkg::word_t trace [$];      // addresses of retired insns
    riscv_pkg::word_t exp_trace [$];
    int               cycles;
    integer           seed;

    riscv_core riscv_core_inst (
        .clk, .arst_n, .insn_addr, .insn, .retire, .halted, .exp_code, .dbg_addr, .dbg_data
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        #1 insn <= rom[insn_addr[7:2]]; // fetch answers within the FETCH cycle
    end

    always @(negedge clk) begin
        if (retire) trace.push_back(insn_addr);
    end

    always @(negedge clk) begin
        if (riscv_core_inst.riscv_core_assert_inst.fail_cnt != 0) begin
            fail_now("an assertion bound to the core failed");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout: core still running after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_word(input string name, input riscv_pkg::word_t exp,
                              input riscv_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_exp(input string name, input riscv_pkg::exp_code_e exp,
                             input riscv_pkg::exp_code_e act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %s got %s", $time, name, exp.name(), act.name());
            stop_run();
        end
    endtask

    // instruction encoders
    function automatic riscv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic riscv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
    endfunction

    function automatic riscv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_pkg::OPC_STORE};
    endfunction

    function automatic riscv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OPC_BRANCH};
    endfunction

    function automatic riscv_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic riscv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OPC_JAL};
    endfunction

    function automatic riscv_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic new_prog();
        foreach (rom[i]) rom[i] = '0; // all-zero word is undefined
        rom_len = 0;
        exp_trace.delete();
    endtask

    // runs marks an insn that is expected to retire
    task automatic emit(input riscv_pkg::word_t w, input bit runs);
        if (runs) exp_trace.push_back(`RESET_PC + 4 * rom_len);
        rom[rom_len] = w;
        rom_len++;
    endtask

    task automatic load_imm(input logic [4:0] rd, input riscv_pkg::word_t val);
        riscv_pkg::word_t hi;
        hi = val + 32'h800; // compensate the sign-extended low part
        emit(enc_u(hi[31:12], rd, riscv_pkg::OPC_LUI), 1);
        emit(enc_i(val[11:0], rd, 3'b000, rd, riscv_pkg::OPC_OP_IMM), 1);
    endtask

    task automatic run_prog();
        @(posedge clk);
        #1 arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        check_word("insn_addr", `RESET_PC, insn_addr);
        check_bit("retire", 1'b0, retire);
        check_bit("halted", 1'b0, halted);
        check_exp("exp_code", riscv_pkg::NO_EXP, exp_code);
        trace.delete();
        do @(negedge clk); while (!halted);
        check_exp("exp_code", riscv_pkg::UNDEF_INSN, exp_code);
        if (trace.size() != exp_trace.size()) begin
            fail_now($sformatf("core retired %0d instructions, %0d were expected",
                               trace.size(), exp_trace.size()));
        end
        foreach (exp_trace[i]) check_word("insn_addr", exp_trace[i], trace[i]);
    endtask

    task automatic check_reg(input logic [4:0] idx, input riscv_pkg::word_t exp);
        @(posedge clk);
        #1 dbg_addr = idx;
        @(negedge clk);
        check_word($sformatf("x%0d", idx), exp, dbg_data);
    endtask

    task automatic test_op_imm();
        riscv_pkg::word_t a;
        a = $random(seed) | 32'h8000_0000; // negative operand
        new_prog();
        load_imm(1, a);
        emit(enc_i(12'hffb, 1, 3'b000, 2, riscv_pkg::OPC_OP_IMM), 1);  // addi -5
        emit(enc_i(12'h007, 1, 3'b010, 3, riscv_pkg::OPC_OP_IMM), 1);  // slti
        emit(enc_i(12'hfff, 1, 3'b011, 4, riscv_pkg::OPC_OP_IMM), 1);  // sltiu vs all ones
        emit(enc_i(12'h5a5, 1, 3'b100, 5, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'hf00, 1, 3'b110, 6, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'h0f0, 1, 3'b111, 7, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'h003, 1, 3'b001, 8, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'h007, 1, 3'b101, 9, riscv_pkg::OPC_OP_IMM), 1);  // srli
        emit(enc_i(12'h407, 1, 3'b101, 10, riscv_pkg::OPC_OP_IMM), 1); // srai
        emit(enc_i(12'h064, 1, 3'b011, 11, riscv_pkg::OPC_OP_IMM), 1);
        emit('0, 0);
        run_prog();
        check_reg(2, a + sext12(12'hffb));
        check_reg(3, {31'b0, $signed(a) < 32'sd7});
        check_reg(4, {31'b0, a < sext12(12'hfff)});
        check_reg(5, a ^ sext12(12'h5a5));
        check_reg(6, a | sext12(12'hf00));
        check_reg(7, a & sext12(12'h0f0));
        check_reg(8, a << 3);
        check_reg(9, a >> 7);
        check_reg(10, $signed(a) >>> 7);
        check_reg(11, {31'b0, a < 32'd100});
    endtask

    task automatic test_op_reg();
        riscv_pkg::word_t b;
        riscv_pkg::word_t c;
        b = $random(seed) & 32'h7fff_ffff;
        c = $random(seed) | 32'h8000_0000;
        new_prog();
        load_imm(1, b);
        load_imm(2, c);
        emit(enc_r(7'b0000000, 2, 1, 3'b000, 3), 1);
        emit(enc_r(7'b0100000, 2, 1, 3'b000, 4), 1);  // sub
        emit(enc_r(7'b0000000, 2, 1, 3'b010, 5), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b011, 6), 1);
        emit(enc_r(7'b0000000, 1, 2, 3'b010, 7), 1);
        emit(enc_r(7'b0100000, 1, 2, 3'b101, 8), 1);  // sra
        emit(enc_r(7'b0000000, 1, 2, 3'b101, 9), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b001, 10), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b111, 11), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b110, 12), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b100, 13), 1);
        emit(enc_r(7'b0000000, 2, 1, 3'b000, 0), 1);  // write to x0
        emit('0, 0);
        run_prog();
        check_reg(0, '0);
        check_reg(3, b + c);
        check_reg(4, b - c);
        check_reg(5, {31'b0, $signed(b) < $signed(c)});
        check_reg(6, {31'b0, b < c});
        check_reg(7, {31'b0, $signed(c) < $signed(b)});
        check_reg(8, $signed(c) >>> b[4:0]);
        check_reg(9, c >> b[4:0]);
        check_reg(10, b << c[4:0]);
        check_reg(11, b & c);
        check_reg(12, b | c);
        check_reg(13, b ^ c);
    endtask

    task automatic test_jump();
        new_prog();
        emit(enc_u(20'h12345, 1, riscv_pkg::OPC_LUI), 1);
        emit(enc_u(20'h00010, 2, riscv_pkg::OPC_AUIPC), 1);         // at 4
        emit(enc_j(21'd12, 3), 1);                                  // at 8, to 20
        emit(enc_i(12'd1, 0, 3'b000, 4, riscv_pkg::OPC_OP_IMM), 0);
        emit(enc_i(12'd2, 0, 3'b000, 4, riscv_pkg::OPC_OP_IMM), 0);
        emit(enc_i(12'd37, 0, 3'b000, 5, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'd0, 5, 3'b000, 6, riscv_pkg::OPC_JALR), 1);   // at 24, 37 -> 36
        emit(enc_i(12'd1, 0, 3'b000, 7, riscv_pkg::OPC_OP_IMM), 0);
        emit(enc_i(12'd2, 0, 3'b000, 7, riscv_pkg::OPC_OP_IMM), 0);
        emit(enc_i(12'd9, 0, 3'b000, 8, riscv_pkg::OPC_OP_IMM), 1);
        emit('0, 0);
        run_prog();
        check_reg(1, 32'h1234_5000);
        check_reg(2, 32'd4 + 32'h0001_0000);
        check_reg(3, 32'd8 + 32'd4);
        check_reg(4, '0);
        check_reg(5, 32'd37);
        check_reg(6, 32'd24 + 32'd4);
        check_reg(7, '0);
        check_reg(8, 32'd9);
    endtask

    task automatic test_branch();
        logic [2:0] f3s [12] = '{3'b000, 3'b000, 3'b001, 3'b001, 3'b100, 3'b100,
                                 3'b101, 3'b101, 3'b110, 3'b110, 3'b111, 3'b111};
        logic [4:0] ra [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
        logic [4:0] rb [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
        // x1 = -3 and x2 = x3 = 5, so each condition is taken and then not taken
        bit         taken [12] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};
        riscv_pkg::word_t mask [2];
        mask[0] = '0;
        mask[1] = '0;
        new_prog();
        emit(enc_i(12'hffd, 0, 3'b000, 1, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'd5, 0, 3'b000, 2, riscv_pkg::OPC_OP_IMM), 1);
        emit(enc_i(12'd5, 0, 3'b000, 3, riscv_pkg::OPC_OP_IMM), 1);
        for (int k = 0; k < 12; k++) begin
            emit(enc_b(13'd8, rb[k], ra[k], f3s[k]), 1); // taken skips the marker
            emit(enc_i(12'(1 << (k % 6)), 10 + k / 6, 3'b110, 10 + k / 6,
                       riscv_pkg::OPC_OP_IMM), !taken[k]);
            if (!taken[k]) mask[k / 6] |= 1 << (k % 6);
        end
        emit('0, 0);
        run_prog();
        check_reg(10, mask[0]);
        check_reg(11, mask[1]);
    endtask

    task automatic test_load_store();
        riscv_pkg::word_t w;
        riscv_pkg::word_t b;
        w = $random(seed) | 32'h8000_8080; // negative byte and halfword lanes
        b = $random(seed) | 32'h0000_8080;
        new_prog();
        emit(enc_i(12'h100, 0, 3'b000, 1, riscv_pkg::OPC_OP_IMM), 1);
        load_imm(2, w);
        load_imm(3, b);
        emit(enc_s(12'd0, 2, 1, 3'b010), 1);
        emit(enc_s(12'd4, 2, 1, 3'b010), 1);
        emit(enc_s(12'd8, 2, 1, 3'b010), 1);
        emit(enc_s(12'd5, 3, 1, 3'b000), 1);   // sb into lane 1
        emit(enc_s(12'd10, 3, 1, 3'b001), 1);  // sh into upper half
        emit(enc_i(12'd0, 1, 3'b010, 4, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd3, 1, 3'b000, 5, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd3, 1, 3'b100, 6, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd2, 1, 3'b001, 7, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd0, 1, 3'b101, 8, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd4, 1, 3'b010, 9, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd8, 1, 3'b010, 10, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd5, 1, 3'b000, 11, riscv_pkg::OPC_LOAD), 1);
        emit(enc_i(12'd10, 1, 3'b101, 12, riscv_pkg::OPC_LOAD), 1);
        emit('0, 0);
        run_prog();
        check_reg(4, w);
        check_reg(5, {{24{w[31]}}, w[31:24]});
        check_reg(6, {24'b0, w[31:24]});
        check_reg(7, {{16{w[31]}}, w[31:16]});
        check_reg(8, {16'b0, w[15:0]});
        check_reg(9, {w[31:16], b[7:0], w[7:0]});
        check_reg(10, {b[15:0], w[15:0]});
        check_reg(11, {{24{b[7]}}, b[7:0]});
        check_reg(12, {16'b0, b[15:0]});
    endtask

    task automatic test_undef();
        riscv_pkg::word_t bad [2];
        bad[0] = 32'h0000_0073;                       // ecall, SYSTEM not implemented
        bad[1] = enc_r(7'b0100000, 2, 1, 3'b111, 3);  // and with a bad funct7
        for (int n = 0; n < 2; n++) begin
            new_prog();
            emit(enc_i(12'd1, 0, 3'b000, 1, riscv_pkg::OPC_OP_IMM), 1);
            emit(bad[n], 0);
            emit(enc_i(12'd2, 0, 3'b000, 2, riscv_pkg::OPC_OP_IMM), 0);
            run_prog();
            repeat (5) begin
                @(negedge clk);
                check_bit("retire", 1'b0, retire);
                check_bit("halted", 1'b1, halted);
                check_word("insn_addr", 32'd4, insn_addr); // stuck on the bad insn
            end
            check_reg(1, 32'd1);
            check_reg(2, '0);
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        insn = '0;
        dbg_addr = '0;
        cycles = 0;
        seed = 81777;
        rom_len = 0;
        test_op_imm();
        test_op_reg();
        test_jump();
        test_branch();
        test_load_store();
        test_undef();
        if (riscv_core_inst.riscv_core_assert_inst.fail_cnt != 0) begin
            fail_now("an assertion bound to the core failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
